/* include/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry, 4-way, 16 sets, 32-byte lines

`define CACHE_WAYS       4
`define CACHE_SETS       16

// address split, tag | set index | block offset
`define CACHE_TAG_BITS   23
`define CACHE_IDX_BITS   4
`define CACHE_OFS_BITS   5

// one line as moved on the memory port
`define CACHE_LINE_BITS  256

// way number width
`define CACHE_WAY_BITS   2

`endif

/* design/cache_types_pkg.sv */
`include "cache_cfg.svh"

package cache_types_pkg;

    // address fields, msb first
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0] tag;
        logic [`CACHE_IDX_BITS-1:0] idx;
        logic [`CACHE_OFS_BITS-1:0] ofs;
    } cache_addr_s;

    // same 32-bit word, either raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        cache_addr_s f;
    } cache_addr_u;

    // tag array entry, dirty sits above the tag
    typedef struct packed {
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } cache_tag_t;

    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

endpackage

/* design/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    // miss handling sequence
    // IDLE -> COMPARE -> (WRITEBACK) -> FETCH -> FILL -> COMPARE
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        COMPARE   = 3'd1,   // tag check, hit responds here
        WRITEBACK = 3'd2,   // dirty victim out to memory
        FETCH     = 3'd3,   // line read from memory
        FILL      = 3'd4    // captured line written into the array
    } cache_state_e;

endpackage

/* design/cache_way_store.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_way_store
import cache_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CACHE_IDX_BITS-1:0]  set_idx,
    input  logic                        we,
    input  logic [`CACHE_LINE_BITS/8-1:0] byte_en,
    input  cache_line_t                 wline,
    input  cache_tag_t                  wtag,
    output cache_line_t                 rline,
    output cache_tag_t                  rtag,
    output logic                        rvalid
);

    cache_line_t               data_mem [`CACHE_SETS];
    cache_tag_t                tag_mem  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]    valid_q;
    cache_line_t               merged;

    // old line with the enabled bytes replaced
    always_comb begin
        merged = data_mem[set_idx];
        for (int b = 0; b < `CACHE_LINE_BITS/8; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = wline[b*8 +: 8];
            end
        end
    end

    // data and tag, no reset
    // a write is visible on the read port in the same edge
    always_ff @(posedge clk) begin
        if (we) begin
            data_mem[set_idx] <= merged;
            tag_mem[set_idx]  <= wtag;    // tag entry always rewritten
            rline             <= merged;
            rtag              <= wtag;
        end else begin
            rline <= data_mem[set_idx];
            rtag  <= tag_mem[set_idx];
        end
    end

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            rvalid  <= 1'b0;
        end else begin
            if (we) begin
                valid_q[set_idx] <= 1'b1;
            end
            rvalid <= we | valid_q[set_idx];
        end
    end

endmodule

/* design/plru_tree.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module plru_tree (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CACHE_IDX_BITS-1:0]  set_idx,
    input  logic                        access,
    input  logic [`CACHE_WAY_BITS-1:0]  access_way,
    output logic [`CACHE_WAY_BITS-1:0]  victim
);

    // bit 0 picks pair 0-1 (0) or pair 2-3 (1)
    // bit 1 picks way 0 or 1, bit 2 picks way 2 or 3
    logic [`CACHE_WAYS-2:0] tree_q [`CACHE_SETS];
    logic [`CACHE_WAYS-2:0] cur;

    assign cur = tree_q[set_idx];

    // follow the bits down to the leaf
    always_comb begin
        if (cur[0]) begin
            victim = {1'b1, cur[2]};
        end else begin
            victim = {1'b0, cur[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (access) begin
            // point every node on the path away from the used way
            tree_q[set_idx][0] <= ~access_way[1];
            if (access_way[1]) begin
                tree_q[set_idx][2] <= ~access_way[0];
            end else begin
                tree_q[set_idx][1] <= ~access_way[0];
            end
        end
    end

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl
import cache_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_req,        // either mask nonzero
    input  logic cpu_write,
    input  logic hit,
    input  logic victim_dirty,   // replacement way valid and dirty
    input  logic mem_resp,
    output logic array_we,
    output logic set_dirty,
    output logic fill,           // array takes the fetched line
    output logic mem_read,
    output logic mem_write,
    output logic cpu_resp,
    output logic plru_access
);

    cache_state_e state_q;
    cache_state_e state_d;
    logic         cmp_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (cpu_req) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FETCH;
                end
            end
            WRITEBACK: begin
                if (mem_resp) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (mem_resp) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                state_d = COMPARE;   // retry the lookup, now a hit
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // memory strobes and fill come straight from the state
    assign mem_write = (state_q == WRITEBACK);
    assign mem_read  = (state_q == FETCH);
    assign fill      = (state_q == FILL);

    // hit qualified outputs, only meaningful in COMPARE
    assign cmp_hit     = (state_q == COMPARE) && hit;
    assign cpu_resp    = cmp_hit;
    assign plru_access = cmp_hit;
    assign set_dirty   = cmp_hit && cpu_write;
    assign array_we    = set_dirty || fill;   // write hit or line fill

endmodule

/* design/mutative_cache.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module mutative_cache
import cache_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,

    // cpu side
    input  logic   [31:0]  ufp_addr,
    input  logic   [3:0]   ufp_rmask,
    input  logic   [3:0]   ufp_wmask,
    output logic   [31:0]  ufp_rdata,
    input  logic   [31:0]  ufp_wdata,
    output logic           ufp_resp,

    // memory side, whole lines
    output logic   [31:0]  dfp_addr,
    output logic           dfp_read,
    output logic           dfp_write,
    input  logic   [255:0] dfp_rdata,
    output logic   [255:0] dfp_wdata,
    input  logic           dfp_resp
);

    cache_addr_u                   req;
    cache_addr_u                   wb_addr;
    cache_addr_u                   fetch_addr;
    logic [2:0]                    word;

    cache_line_t                   way_line  [`CACHE_WAYS];
    cache_tag_t                    way_tag   [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]        way_valid;

    logic                          hit;
    logic [`CACHE_WAY_BITS-1:0]    hit_way;
    logic [`CACHE_WAY_BITS-1:0]    plru_victim;
    logic [`CACHE_WAY_BITS-1:0]    repl_way;
    logic [`CACHE_WAY_BITS-1:0]    tgt_way;
    logic                          victim_dirty;

    logic                          array_we;
    logic                          set_dirty;
    logic                          fill;
    logic                          plru_access;

    cache_line_t                   fill_line;
    cache_line_t                   wline;
    logic [`CACHE_LINE_BITS/8-1:0] byte_en;
    cache_tag_t                    wtag;

    assign req.raw = ufp_addr;
    assign word    = req.f.ofs[`CACHE_OFS_BITS-1:2];   // word slot in the line

    generate
        for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
            cache_way_store way_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .set_idx (req.f.idx),
                .we      (array_we && (tgt_way == `CACHE_WAY_BITS'(i))),
                .byte_en (byte_en),
                .wline   (wline),
                .wtag    (wtag),
                .rline   (way_line[i]),
                .rtag    (way_tag[i]),
                .rvalid  (way_valid[i])
            );
        end
    endgenerate

    // tag compare, first matching valid way
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (!hit && way_valid[i] && (way_tag[i].tag == req.f.tag)) begin
                hit     = 1'b1;
                hit_way = `CACHE_WAY_BITS'(i);
            end
        end
    end

    // lowest invalid way wins over the tree choice
    always_comb begin
        repl_way = plru_victim;
        for (int i = `CACHE_WAYS-1; i >= 0; i--) begin
            if (!way_valid[i]) begin
                repl_way = `CACHE_WAY_BITS'(i);
            end
        end
    end

    assign victim_dirty = way_valid[repl_way] && way_tag[repl_way].dirty;
    assign tgt_way      = fill ? repl_way : hit_way;

    // line is only valid with dfp_resp, hold it for the FILL cycle
    always_ff @(posedge clk) begin
        if (dfp_read && dfp_resp) begin
            fill_line <= dfp_rdata;
        end
    end

    // write steering: full line on fill, one masked word on a write hit
    always_comb begin
        if (fill) begin
            wline   = fill_line;
            byte_en = '1;
        end else begin
            wline   = cache_line_t'(ufp_wdata) << (32 * word);
            byte_en = (`CACHE_LINE_BITS/8)'(ufp_wmask) << (4 * word);
        end
    end

    assign wtag.dirty = set_dirty;   // fill stores a clean line
    assign wtag.tag   = req.f.tag;

    assign ufp_rdata = way_line[hit_way][32*word +: 32];

    // writeback goes to the victim's own line, fetch to the request line
    always_comb begin
        wb_addr.f.tag    = way_tag[repl_way].tag;
        wb_addr.f.idx    = req.f.idx;
        wb_addr.f.ofs    = '0;
        fetch_addr       = req;
        fetch_addr.f.ofs = '0;
    end

    assign dfp_addr  = dfp_write ? wb_addr.raw : fetch_addr.raw;
    assign dfp_wdata = way_line[repl_way];

    plru_tree plru_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_idx    (req.f.idx),
        .access     (plru_access),
        .access_way (hit_way),
        .victim     (plru_victim)
    );

    cache_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (|ufp_rmask || |ufp_wmask),
        .cpu_write    (|ufp_wmask),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_resp     (dfp_resp),
        .array_we     (array_we),
        .set_dirty    (set_dirty),
        .fill         (fill),
        .mem_read     (dfp_read),
        .mem_write    (dfp_write),
        .cpu_resp     (ufp_resp),
        .plru_access  (plru_access)
    );

endmodule

/* test/mutative_cache_chk.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module mutative_cache_chk (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ufp_resp,
    input  logic [31:0] dfp_addr,
    input  logic        dfp_read,
    input  logic        dfp_write,
    input  logic        dfp_resp
);

    int unsigned assert_fails = 0;   // read by the testbench at the end

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dfp_read && dfp_write))
    else begin
        assert_fails++;
        $error("dfp_read and dfp_write high in the same cycle");
    end

    // cpu response is a single pulse
    resp_single: assert property (@(posedge clk) disable iff (!rst_n)
        ufp_resp |=> !ufp_resp)
    else begin
        assert_fails++;
        $error("ufp_resp held for more than one cycle");
    end

    line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_read || dfp_write) |-> (dfp_addr[`CACHE_OFS_BITS-1:0] == '0))
    else begin
        assert_fails++;
        $error("dfp_addr not line aligned while a strobe is high");
    end

    // levels drop only after the memory answers
    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_read && !dfp_resp) |=> dfp_read)
    else begin
        assert_fails++;
        $error("dfp_read dropped before dfp_resp");
    end

    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_write && !dfp_resp) |=> dfp_write)
    else begin
        assert_fails++;
        $error("dfp_write dropped before dfp_resp");
    end

endmodule

/* test/mutative_cache_tb.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module mutative_cache_tb
import cache_types_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED           = 32'h3777_5e08;

    logic         clk;
    logic         rst_n;
    logic [31:0]  ufp_addr;
    logic [3:0]   ufp_rmask;
    logic [3:0]   ufp_wmask;
    logic [31:0]  ufp_rdata;
    logic [31:0]  ufp_wdata;
    logic         ufp_resp;
    logic [31:0]  dfp_addr;
    logic         dfp_read;
    logic         dfp_write;
    logic [255:0] dfp_rdata;
    logic [255:0] dfp_wdata;
    logic         dfp_resp;

    logic [31:0]  stim_seed;
    logic [31:0]  mem_seed;
    int           errors;
    int           checks;
    int           tests;
    bit           timed_out;

    logic [32:0]  mem_ops [$];     // {write, line address} as seen by memory
    cache_line_t  wb_lines [$];
    cache_line_t  mem_lines [logic [31-`CACHE_OFS_BITS:0]];

    // reference model, words plus tag/valid/dirty/plru state
    logic [31:0]                 ref_mem [logic [29:0]];
    logic [`CACHE_TAG_BITS-1:0]  m_tag   [`CACHE_SETS][`CACHE_WAYS];
    bit                          m_valid [`CACHE_SETS][`CACHE_WAYS];
    bit                          m_dirty [`CACHE_SETS][`CACHE_WAYS];
    bit [`CACHE_WAYS-2:0]        m_plru  [`CACHE_SETS];

    mutative_cache dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_rdata (ufp_rdata),
        .ufp_wdata (ufp_wdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

    bind mutative_cache mutative_cache_chk chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_resp  (dfp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // backing store pattern, unique per word address
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        if (ref_mem.exists(a[31:2])) begin
            return ref_mem[a[31:2]];
        end
        return init_word({a[31:2], 2'b00});
    endfunction

    function automatic cache_line_t model_line(input logic [31:0] line_addr);
        cache_line_t l;
        for (int w = 0; w < 8; w++) begin
            l[32*w +: 32] = ref_word(line_addr + 32'(4 * w));
        end
        return l;
    endfunction

    function automatic cache_line_t read_line(input logic [31:0] line_addr);
        cache_line_t l;
        if (mem_lines.exists(line_addr[31:`CACHE_OFS_BITS])) begin
            return mem_lines[line_addr[31:`CACHE_OFS_BITS]];
        end
        for (int w = 0; w < 8; w++) begin
            l[32*w +: 32] = init_word(line_addr + 32'(4 * w));
        end
        return l;
    endfunction

    task automatic draw(output logic [31:0] r);
        stim_seed = lcg(stim_seed);
        r = stim_seed;
    endtask

    // line memory, answers each strobe after 1 to 4 cycles
    initial begin : memory_model
        int unsigned delay;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            dfp_resp = 1'b0;
            if (rst_n && (dfp_read || dfp_write)) begin
                mem_seed = lcg(mem_seed);
                delay = 1 + mem_seed[31:30];
                mem_ops.push_back({dfp_write, dfp_addr});
                if (dfp_write) begin
                    wb_lines.push_back(dfp_wdata);
                    mem_lines[dfp_addr[31:`CACHE_OFS_BITS]] = dfp_wdata;
                end else begin
                    dfp_rdata = read_line(dfp_addr);
                end
                repeat (delay - 1) @(negedge clk);
                dfp_resp = 1'b1;
            end
        end
    end

    // one cpu request, predicted by the model and checked on completion
    task automatic access(input logic [31:0] addr, input logic [3:0] rmask,
                          input logic [3:0] wmask, input logic [31:0] wdata);
        cache_addr_u  a;
        logic [1:0]   way;
        bit           hit;
        bit           seen;
        logic [31:0]  old_word;
        logic [31:0]  new_word;
        logic [31:0]  got;
        logic [32:0]  exp_ops [$];
        cache_line_t  exp_lines [$];
        int           cycles;
        if (timed_out) return;
        a.raw = addr;
        hit   = 1'b0;
        way   = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (!hit && m_valid[a.f.idx][i] && m_tag[a.f.idx][i] == a.f.tag) begin
                hit = 1'b1;
                way = 2'(i);
            end
        end
        if (!hit) begin
            way = m_plru[a.f.idx][0] ? {1'b1, m_plru[a.f.idx][2]} : {1'b0, m_plru[a.f.idx][1]};
            for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
                if (!m_valid[a.f.idx][i]) way = 2'(i);   // free way first
            end
            if (m_valid[a.f.idx][way] && m_dirty[a.f.idx][way]) begin
                exp_ops.push_back({1'b1, m_tag[a.f.idx][way], a.f.idx, 5'b0});
                exp_lines.push_back(model_line({m_tag[a.f.idx][way], a.f.idx, 5'b0}));
            end
            exp_ops.push_back({1'b0, a.f.tag, a.f.idx, 5'b0});
            m_tag[a.f.idx][way]   = a.f.tag;
            m_valid[a.f.idx][way] = 1'b1;
            m_dirty[a.f.idx][way] = 1'b0;
        end
        m_plru[a.f.idx][0] = ~way[1];
        if (way[1]) m_plru[a.f.idx][2] = ~way[0];
        else        m_plru[a.f.idx][1] = ~way[0];
        old_word = ref_word(addr);
        new_word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) new_word[8*b +: 8] = wdata[8*b +: 8];
        end
        if (|wmask) begin
            ref_mem[addr[31:2]]   = new_word;
            m_dirty[a.f.idx][way] = 1'b1;
        end

        ufp_addr  = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp && cycles < TIMEOUT_CYCLES);
        seen = ufp_resp;
        got  = ufp_rdata;
        if (seen) @(negedge clk);
        ufp_rmask = '0;
        ufp_wmask = '0;

        checks++;
        if (!seen) begin
            $display("no ufp_resp for address %h within %0d cycles", addr, TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
            return;
        end
        if (|rmask && got !== old_word) begin
            $display("mismatch ufp_rdata @%h: got %h expected %h", addr, got, old_word);
            errors++;
        end
        if (mem_ops.size() != exp_ops.size()) begin
            $display("address %h caused %0d memory operations, model expects %0d",
                     addr, mem_ops.size(), exp_ops.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_ops.size(); i++) begin
                if (mem_ops[i] !== exp_ops[i]) begin
                    $display("mismatch {dfp_write,dfp_addr}: got %h expected %h",
                             mem_ops[i], exp_ops[i]);
                    errors++;
                end
            end
        end
        for (int i = 0; i < exp_lines.size() && i < wb_lines.size(); i++) begin
            if (wb_lines[i] !== exp_lines[i]) begin
                $display("mismatch dfp_wdata: got %h expected %h", wb_lines[i], exp_lines[i]);
                errors++;
            end
        end
        mem_ops.delete();
        wb_lines.delete();
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("%-16s done, %0d errors", name, errors - err_before);
    endtask

    initial begin : main
        int                         err0;
        logic [31:0]                r;
        logic [31:0]                d;
        cache_addr_u                a;
        logic [`CACHE_TAG_BITS-1:0] base;
        rst_n     = 1'b0;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        stim_seed = SEED;
        mem_seed  = lcg(SEED);   // separate stream for memory delays
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        checks++;
        if (ufp_resp !== 1'b0 || dfp_read !== 1'b0 || dfp_write !== 1'b0) begin
            $display("outputs not idle after reset: ufp_resp %h dfp_read %h dfp_write %h",
                     ufp_resp, dfp_read, dfp_write);
            errors++;
        end
        draw(r);
        access({r[31:2], 2'b00}, 4'hf, 4'h0, 32'h0);
        end_test("reset_state", err0);

        err0 = errors;
        draw(r);
        draw(d);
        access({r[31:2], 2'b00}, 4'hf, 4'h0, 32'h0);
        access({r[31:2], 2'b00}, 4'h0, 4'b0101, d);
        access({r[31:2], 2'b00}, 4'hf, 4'h0, 32'h0);   // merged bytes, no strobe
        end_test("write_hit", err0);

        // four tags fill set 5, reuse three, fifth tag evicts the plru way
        err0 = errors;
        draw(r);
        base = r[31:9];
        for (int k = 0; k < 4; k++) access({base + 23'(k), 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        access({base + 23'd1, 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        access({base + 23'd3, 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        access({base, 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        access({base + 23'd4, 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        for (int k = 0; k < 4; k++) access({base + 23'(k), 4'd5, 5'd4}, 4'hf, 4'h0, 32'h0);
        end_test("plru_replace", err0);

        err0 = errors;
        draw(r);
        base = r[31:9];
        for (int k = 0; k < 4; k++) begin
            draw(d);
            access({base + 23'(k), 4'd9, 3'(k), 2'b00}, 4'h0, 4'hf, d);
        end
        access({base + 23'd4, 4'd9, 5'd0}, 4'hf, 4'h0, 32'h0);
        end_test("dirty_evict", err0);

        // eight tags over four sets keep evictions frequent
        err0 = errors;
        for (int n = 0; n < 400 && !timed_out; n++) begin
            draw(r);
            draw(d);
            a.f.tag = 23'h100 + 23'(r[31:29]);
            a.f.idx = {r[28:27], 2'b10};
            a.f.ofs = {r[26:24], 2'b00};
            if (r[23]) access(a.raw, 4'h0, (r[22:19] == 4'h0) ? 4'hf : r[22:19], d);
            else       access(a.raw, 4'hf, 4'h0, 32'h0);
        end
        end_test("random_traffic", err0);

        errors += dut_i.chk_i.assert_fails;
        $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
design/cache_types_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_way_store.sv
design/plru_tree.sv
design/cache_ctrl.sv
design/mutative_cache.sv
test/mutative_cache_chk.sv
test/mutative_cache_tb.sv

/* Bender.yml */
package:
  name: mutative_cache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cache_types_pkg.sv
      - design/cache_ctrl_pkg.sv
      - design/cache_way_store.sv
      - design/plru_tree.sv
      - design/cache_ctrl.sv
      - design/mutative_cache.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mutative_cache_chk.sv
      - test/mutative_cache_tb.sv
